/* verilog.f */
hw/cpu_pkg.sv
hw/acc_shift_decode.sv
hw/micro_sequencer.sv
hw/datapath.sv
hw/bus_arbiter.sv
hw/program_ram.sv
hw/cpu_top.sv
test/cpu_assert.sv
test/cpu_tb.sv

/* Makefile */
VERILATOR := verilator
TOP       := cpu_tb
FILELIST  := verilog.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --assert --timescale 1ns/100ps -j 0 --top-module $(TOP) --Mdir $(OBJ_DIR)
RUN_ARGS  := +verilator+error+limit+1000
SIM       := $(OBJ_DIR)/V$(TOP)
PASS_MSG  := SIMULATION PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

run: compile
	@out="$$(./$(SIM) $(RUN_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* test/cpu_tb.sv */
module cpu_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int          MEM_DEPTH      = 256;
    localparam logic [31:0] SEED           = 32'hd7aa_a701;
    localparam int          RANDOM_RUNS    = 16;
    localparam int          RUNS           = RANDOM_RUNS + 1;
    localparam int          INSTR_PER_RUN  = 10;
    localparam int          PROG_LEN       = 11;
    localparam int          TIMEOUT_CYCLES = 64 * RUNS * INSTR_PER_RUN + 200;

    // 6502 accumulator-mode opcodes
    localparam logic [7:0] ASL_A = 8'h0A;
    localparam logic [7:0] ROL_A = 8'h2A;
    localparam logic [7:0] LSR_A = 8'h4A;
    localparam logic [7:0] ROR_A = 8'h6A;

    // Program after the LDA immediate and its operand
    localparam logic [7:0] BODY [0:8] = '{
        8'h0A, 8'h2A, 8'h6A, 8'h4A, 8'h38, 8'h6A, 8'h18, 8'h2A, 8'h00
    };

    logic             clk;
    logic             rst_n;
    cpu_pkg::wb_req_t host_req;
    cpu_pkg::wb_rsp_t host_rsp;
    logic [7:0]       acc;
    logic             carry;
    logic             zero;
    logic             negative;
    logic             sync;
    logic             halted;
    int               errors;
    int unsigned      cycle_count;

    cpu_top #(
        .MEM_DEPTH (MEM_DEPTH)
    ) cpu_top_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .host_req (host_req),
        .host_rsp (host_rsp),
        .acc      (acc),
        .carry    (carry),
        .zero     (zero),
        .negative (negative),
        .sync     (sync),
        .halted   (halted)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    function automatic logic [7:0] program_byte(input int idx, input logic [7:0] operand);
        if (idx == 0) begin
            return cpu_pkg::OP_LDA_IMM;
        end
        if (idx == 1) begin
            return operand;
        end
        return BODY[idx-2];
    endfunction

    // Reference model of the program, returns carry and accumulator at halt
    function automatic logic [8:0] expected_state(input logic [7:0] operand);
        logic [7:0] a;
        logic       c;
        logic       nc;
        a = operand;
        c = 1'b0;
        for (int i = 0; i < 9; i++) begin
            nc = c;
            case (BODY[i])
                ASL_A: begin
                    nc = a[7];
                    a  = {a[6:0], 1'b0};
                end
                ROL_A: begin
                    nc = a[7];
                    a  = {a[6:0], c};
                end
                LSR_A: begin
                    nc = a[0];
                    a  = {1'b0, a[7:1]};
                end
                ROR_A: begin
                    nc = a[0];
                    a  = {c, a[7:1]};
                end
                cpu_pkg::OP_SEC: nc = 1'b1;
                cpu_pkg::OP_CLC: nc = 1'b0;
                default: ;
            endcase
            c = nc;
        end
        return {c, a};
    endfunction

    // One Wishbone access on the host port, called on a rising edge
    task automatic host_access(input logic write, input logic [7:0] addr,
                               input logic [7:0] wdata, output logic [7:0] rdata);
        host_req <= '{cyc: 1'b1, stb: 1'b1, we: write, adr: addr, dat: wdata};
        do begin
            @(negedge clk);
        end while (!host_rsp.ack);
        rdata = host_rsp.dat;
        @(posedge clk);
    endtask

    task automatic run_program(input logic [7:0] operand);
        logic [7:0] rdata;
        logic [8:0] expected;
        @(posedge clk);
        rst_n    <= 1'b0;
        // Host holds cyc from reset on so the core cannot fetch early
        host_req <= '{cyc: 1'b1, stb: 1'b0, we: 1'b0, adr: 8'h00, dat: 8'h00};
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        for (int i = 0; i < PROG_LEN; i++) begin
            host_access(1'b1, 8'(i), program_byte(i, operand), rdata);
        end
        for (int i = 0; i < PROG_LEN; i++) begin
            host_access(1'b0, 8'(i), 8'h00, rdata);
            if (rdata !== program_byte(i, operand)) begin
                $display("Fail at %0t: address %0d read back %02h, expected %02h",
                         $time, i, rdata, program_byte(i, operand));
                errors++;
            end
        end
        host_req <= '0;
        while (!halted) begin
            @(negedge clk);
        end
        expected = expected_state(operand);
        if (acc !== expected[7:0] || carry !== expected[8]) begin
            $display("Fail at %0t: operand %02h halted with A=%02h C=%0b, expected A=%02h C=%0b",
                     $time, operand, acc, carry, expected[7:0], expected[8]);
            errors++;
        end
    endtask

    initial begin
        logic [31:0] rnd;
        int          assert_errors;
        rst_n       = 1'b0;
        host_req    = '0;
        errors      = 0;
        cycle_count = 0;
        void'($urandom(SEED));
        run_program(8'd96);
        for (int r = 0; r < RANDOM_RUNS; r++) begin
            rnd = $urandom();
            run_program(rnd[7:0]);
        end
        repeat (2) @(posedge clk);
        assert_errors = cpu_top_inst.cpu_assert_inst.fail_count;
        $display("Error count: %0d testbench, %0d assertion", errors, assert_errors);
        if (errors == 0 && assert_errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

/* test/cpu_assert.sv */
module cpu_assert (
    input logic             clk,
    input logic             rst_n,
    input cpu_pkg::wb_req_t host_req,
    input cpu_pkg::wb_rsp_t host_rsp,
    input cpu_pkg::wb_req_t core_req,
    input cpu_pkg::wb_rsp_t core_rsp,
    input cpu_pkg::wb_req_t mem_req,
    input logic [1:0]       gnt,
    input cpu_pkg::opcode_u ir,
    input logic [7:0]       acc,
    input logic             carry,
    input logic             zero,
    input logic             negative,
    input logic             sync,
    input logic             halted
);
    timeunit 1ns;
    timeprecision 100ps;

    int         fail_count = 0;
    logic [7:0] last_acc;
    logic       last_carry;
    logic       have_last;
    logic       shift_op;

    // Expected {carry, acc} after the shift selected by aaa
    function automatic logic [8:0] shift_result(input logic [2:0] kind, input logic [7:0] a,
                                                input logic c);
        case (kind)
            3'b000:  return {a[7], a[6:0], 1'b0};
            3'b001:  return {a[7], a[6:0], c};
            3'b010:  return {a[0], 1'b0, a[7:1]};
            default: return {a[0], c, a[7:1]};
        endcase
    endfunction

    assign shift_op = ir.raw inside {8'h0A, 8'h2A, 8'h4A, 8'h6A};

    // Accumulator and carry as seen at the previous opcode fetch
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            have_last  <= 1'b0;
            last_acc   <= 8'h00;
            last_carry <= 1'b0;
        end else if (sync) begin
            have_last  <= 1'b1;
            last_acc   <= acc;
            last_carry <= carry;
        end
    end

    // The host takes the bus unless the core already holds it
    host_routed: assert property (@(posedge clk) disable iff (!rst_n)
        host_req.cyc && !$past(gnt[0]) |-> mem_req == host_req)
        else begin
            fail_count++;
            $error("Host request not routed to memory while the core did not hold the bus");
        end

    // The core keeps its grant and wins a bus the host leaves idle
    core_routed: assert property (@(posedge clk) disable iff (!rst_n)
        core_req.cyc && ($past(gnt[0]) || !host_req.cyc) |-> mem_req == core_req)
        else begin
            fail_count++;
            $error("Core request not routed to memory while the core owned the bus");
        end

    single_ack: assert property (@(posedge clk) disable iff (!rst_n)
        !(host_rsp.ack && core_rsp.ack))
        else begin
            fail_count++;
            $error("Ack returned to both masters");
        end

    shift_rule: assert property (@(posedge clk) disable iff (!rst_n)
        sync && have_last && shift_op |->
            {carry, acc} == shift_result(ir.f.aaa, last_acc, last_carry))
        else begin
            fail_count++;
            $error("Shift result wrong for opcode %02h", ir.raw);
        end

    flags_match: assert property (@(posedge clk) disable iff (!rst_n)
        zero == (acc == 8'h00) && negative == acc[7])
        else begin
            fail_count++;
            $error("Zero or negative flag does not match the accumulator");
        end

    halt_sticky: assert property (@(posedge clk) disable iff (!rst_n)
        halted |=> (halted || !rst_n))
        else begin
            fail_count++;
            $error("Halted dropped without a reset");
        end

    halt_quiet: assert property (@(posedge clk) disable iff (!rst_n)
        halted |-> !sync && ir.raw == 8'h00)
        else begin
            fail_count++;
            $error("Sync after halt, or halted on a non-halt opcode");
        end

endmodule

bind cpu_top cpu_assert cpu_assert_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .host_req (host_req),
    .host_rsp (host_rsp),
    .core_req (core_req),
    .core_rsp (core_rsp),
    .mem_req  (mem_req),
    .gnt      (bus_arbiter_inst.gnt),
    .ir       (micro_sequencer_inst.ir),
    .acc      (acc),
    .carry    (carry),
    .zero     (zero),
    .negative (negative),
    .sync     (sync),
    .halted   (halted)
);

/* hw/cpu_top.sv */
module cpu_top #(
    parameter int MEM_DEPTH = 256
) (
    input  logic             clk,
    input  logic             rst_n,
    input  cpu_pkg::wb_req_t host_req,
    output cpu_pkg::wb_rsp_t host_rsp,
    output logic [7:0]       acc,
    output logic             carry,
    output logic             zero,
    output logic             negative,
    output logic             sync,
    output logic             halted
);

    cpu_pkg::ctrl_flags_t flags;
    cpu_pkg::wb_req_t     core_req;
    cpu_pkg::wb_rsp_t     core_rsp;
    cpu_pkg::wb_req_t     mem_req;
    cpu_pkg::wb_rsp_t     mem_rsp;
    logic                 bus_done;
    logic [7:0]           fetch_data;

    micro_sequencer micro_sequencer_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .bus_done   (bus_done),
        .fetch_data (fetch_data),
        .carry_flag (carry),
        .flags      (flags),
        .sync       (sync),
        .halted     (halted)
    );

    datapath datapath_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .flags      (flags),
        .wb_req     (core_req),
        .wb_rsp     (core_rsp),
        .bus_done   (bus_done),
        .fetch_data (fetch_data),
        .acc        (acc),
        .carry      (carry),
        .zero       (zero),
        .negative   (negative)
    );

    // Core fetch port is master 0, the host port master 1
    bus_arbiter bus_arbiter_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .core_req (core_req),
        .core_rsp (core_rsp),
        .host_req (host_req),
        .host_rsp (host_rsp),
        .mem_req  (mem_req),
        .mem_rsp  (mem_rsp)
    );

    program_ram #(
        .DEPTH (MEM_DEPTH)
    ) program_ram_inst (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (mem_req),
        .rsp   (mem_rsp)
    );

endmodule

/* hw/program_ram.sv */
module program_ram #(
    parameter int DEPTH = 256
) (
    input  logic             clk,
    input  logic             rst_n,
    input  cpu_pkg::wb_req_t req,
    output cpu_pkg::wb_rsp_t rsp
);

    logic [7:0] mem [DEPTH];
    logic [7:0] rdata_q;
    logic       busy;
    logic       ack_q;
    logic       req_on;

    assign req_on = req.cyc && req.stb;

    // Idle -> wait state -> ack, a new access may start the cycle after ack
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy  <= 1'b0;
            ack_q <= 1'b0;
        end else begin
            busy  <= req_on && !busy && !ack_q;
            ack_q <= busy && req_on;
        end
    end

    always_ff @(posedge clk) begin
        if (busy) rdata_q <= mem[req.adr];
        if (ack_q && req_on && req.we) mem[req.adr] <= req.dat;
    end

    assign rsp.ack = ack_q;
    assign rsp.dat = rdata_q;

endmodule

/* hw/bus_arbiter.sv */
module bus_arbiter (
    input  logic             clk,
    input  logic             rst_n,
    input  cpu_pkg::wb_req_t core_req,
    output cpu_pkg::wb_rsp_t core_rsp,
    input  cpu_pkg::wb_req_t host_req,
    output cpu_pkg::wb_rsp_t host_rsp,
    output cpu_pkg::wb_req_t mem_req,
    input  cpu_pkg::wb_rsp_t mem_rsp
);

    // Bit 0 grants the core, bit 1 the host
    logic [1:0] gnt;
    logic [1:0] gnt_q;

    always_comb begin
        if (gnt_q[1] && host_req.cyc) begin
            gnt = 2'b10;
        end else if (gnt_q[0] && core_req.cyc) begin
            gnt = 2'b01;
        end else if (host_req.cyc) begin
            // Idle bus, host has priority
            gnt = 2'b10;
        end else if (core_req.cyc) begin
            gnt = 2'b01;
        end else begin
            gnt = 2'b00;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            gnt_q <= 2'b00;
        end else begin
            gnt_q <= gnt;
        end
    end

    always_comb begin
        mem_req = '0;
        if (gnt[1]) begin
            mem_req = host_req;
        end else if (gnt[0]) begin
            mem_req = core_req;
        end
    end

    always_comb begin
        core_rsp = '0;
        host_rsp = '0;
        if (gnt[0]) core_rsp = mem_rsp;
        if (gnt[1]) host_rsp = mem_rsp;
    end

endmodule

/* hw/datapath.sv */
module datapath (
    input  logic                 clk,
    input  logic                 rst_n,
    input  cpu_pkg::ctrl_flags_t flags,
    output cpu_pkg::wb_req_t     wb_req,
    input  cpu_pkg::wb_rsp_t     wb_rsp,
    output logic                 bus_done,
    output logic [7:0]           fetch_data,
    output logic [7:0]           acc,
    output logic                 carry,
    output logic                 zero,
    output logic                 negative
);

    logic [15:0] pc;
    logic [15:0] pc_next;
    logic [7:0]  abh;
    logic [7:0]  abl;
    logic [7:0]  adh;
    logic [7:0]  adl;
    logic [7:0]  data_q;
    logic [7:0]  alu_q;
    logic        alu_c_q;
    logic [7:0]  sb_drive;
    logic [7:0]  sb;
    logic [7:0]  db;
    logic [7:0]  alu_a;
    logic [7:0]  alu_b;
    logic [8:0]  sum;
    logic [7:0]  alu_res;
    logic        alu_cout;
    logic        page0;

    assign pc_next = pc + {15'd0, flags[cpu_pkg::PC_INC]};
    assign adh = flags[cpu_pkg::SET_ADH_TO_PCH] ? pc_next[15:8] : 8'h00;
    assign adl = flags[cpu_pkg::SET_ADL_TO_PCL] ? pc_next[7:0] : 8'h00;

    // SB sources of its own; the pass gate ties SB and DB in either direction
    assign sb_drive = flags[cpu_pkg::SET_SB_TO_ACC] ? acc :
                      flags[cpu_pkg::SET_SB_TO_ALU] ? alu_q : 8'h00;
    assign db = flags[cpu_pkg::SET_DB_TO_DATA] ? data_q :
                flags[cpu_pkg::SET_SB_TO_DB]   ? sb_drive : 8'h00;
    assign sb = (flags[cpu_pkg::SET_SB_TO_ACC] || flags[cpu_pkg::SET_SB_TO_ALU]) ? sb_drive :
                flags[cpu_pkg::SET_SB_TO_DB] ? db : 8'h00;

    assign alu_a = flags[cpu_pkg::SET_INPUT_A_TO_SB] ? sb : 8'h00;
    assign alu_b = flags[cpu_pkg::SET_INPUT_B_TO_DB] ? db : 8'h00;
    assign sum   = {1'b0, alu_a} + {1'b0, alu_b} + {8'd0, flags[cpu_pkg::SET_ALU_CARRY_HIGH]};

    always_comb begin
        if (flags[cpu_pkg::ALU_ROT]) begin
            // Carry in enters bit 7, bit 0 drops into carry out
            alu_res  = {flags[cpu_pkg::SET_ALU_CARRY_HIGH], alu_a[7:1]};
            alu_cout = alu_a[0];
        end else if (flags[cpu_pkg::ALU_ADD]) begin
            alu_res  = sum[7:0];
            alu_cout = sum[8];
        end else begin
            alu_res  = alu_a;
            alu_cout = 1'b0;
        end
    end

    // Only page zero is backed by memory, other pages read as 00
    assign page0 = (abh == 8'h00);

    always_comb begin
        wb_req     = '0;
        wb_req.cyc = flags[cpu_pkg::FETCH] && page0;
        wb_req.stb = flags[cpu_pkg::FETCH] && page0;
        wb_req.adr = abl;
    end

    assign bus_done   = flags[cpu_pkg::FETCH] && (page0 ? wb_rsp.ack : 1'b1);
    assign fetch_data = page0 ? wb_rsp.dat : cpu_pkg::OP_HALT;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc       <= 16'd0;
            abh      <= 8'h00;
            abl      <= 8'h00;
            acc      <= 8'h00;
            carry    <= 1'b0;
            zero     <= 1'b1;
            negative <= 1'b0;
        end else begin
            pc <= pc_next;
            if (flags[cpu_pkg::LOAD_ABH]) abh <= adh;
            if (flags[cpu_pkg::LOAD_ABL]) abl <= adl;
            if (flags[cpu_pkg::SET_ACC_TO_SB]) begin
                acc      <= sb;
                zero     <= (sb == 8'h00);
                negative <= sb[7];
            end
            if (flags[cpu_pkg::CLEAR_CARRY]) begin
                carry <= 1'b0;
            end else if (flags[cpu_pkg::SET_CARRY]) begin
                carry <= 1'b1;
            end else if (flags[cpu_pkg::SET_ACC_TO_SB] && flags[cpu_pkg::SET_SB_TO_ALU]) begin
                carry <= alu_c_q;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (flags[cpu_pkg::LOAD_DATA] && bus_done) data_q <= fetch_data;
        if (flags[cpu_pkg::LOAD_ALU]) begin
            alu_q   <= alu_res;
            alu_c_q <= alu_cout;
        end
    end

endmodule

/* hw/micro_sequencer.sv */
module micro_sequencer (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 bus_done,
    input  logic [7:0]           fetch_data,
    input  logic                 carry_flag,
    output cpu_pkg::ctrl_flags_t flags,
    output logic                 sync,
    output logic                 halted
);

    cpu_pkg::opcode_u     ir;
    cpu_pkg::ctrl_flags_t shift_flags;
    logic [2:0]           state;
    logic                 started;
    logic                 opfetch;
    logic                 is_shift;

    // Move PC on and point the address latches at it
    function automatic cpu_pkg::ctrl_flags_t pc_advance(input logic last);
        cpu_pkg::ctrl_flags_t f;
        f = '0;
        f[cpu_pkg::PC_INC]         = 1'b1;
        f[cpu_pkg::SET_ADH_TO_PCH] = 1'b1;
        f[cpu_pkg::LOAD_ABH]       = 1'b1;
        f[cpu_pkg::SET_ADL_TO_PCL] = 1'b1;
        f[cpu_pkg::LOAD_ABL]       = 1'b1;
        f[cpu_pkg::END_INSTR]      = last;
        return f;
    endfunction

    acc_shift_decode acc_shift_decode_inst (
        .carry_flag (carry_flag),
        .state      (state),
        .shift_sel  (ir.f.aaa),
        .flags      (shift_flags)
    );

    // ASL, ROL, LSR and ROR A; the rest of the aaa range runs as NOP
    assign is_shift = (ir.f.cc == cpu_pkg::SHIFT_CC) && (ir.f.bbb == cpu_pkg::SHIFT_BBB) &&
                      !ir.f.aaa[2];

    always_comb begin
        flags = '0;
        if (started && !halted) begin
            if (opfetch) begin
                flags[cpu_pkg::FETCH]   = 1'b1;
                flags[cpu_pkg::LOAD_IR] = 1'b1;
            end else if (is_shift) begin
                flags = shift_flags;
            end else begin
                case (ir.raw)
                    cpu_pkg::OP_LDA_IMM: begin
                        case (state)
                            3'd0: flags = pc_advance(1'b0);
                            3'd1: begin
                                flags[cpu_pkg::FETCH]     = 1'b1;
                                flags[cpu_pkg::LOAD_DATA] = 1'b1;
                            end
                            3'd2: begin
                                flags = pc_advance(1'b1);
                                flags[cpu_pkg::SET_DB_TO_DATA] = 1'b1;
                                flags[cpu_pkg::SET_SB_TO_DB]   = 1'b1;
                                flags[cpu_pkg::SET_ACC_TO_SB]  = 1'b1;
                            end
                            default: ;
                        endcase
                    end
                    cpu_pkg::OP_HALT: flags[cpu_pkg::HALT] = 1'b1;
                    default: begin
                        // CLC, SEC, NOP and unknown opcodes
                        if (state == 3'd0) begin
                            flags[cpu_pkg::CLEAR_CARRY] = (ir.raw == cpu_pkg::OP_CLC);
                            flags[cpu_pkg::SET_CARRY]   = (ir.raw == cpu_pkg::OP_SEC);
                        end else begin
                            flags = pc_advance(1'b1);
                        end
                    end
                endcase
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            started <= 1'b0;
            opfetch <= 1'b0;
            state   <= 3'd0;
            halted  <= 1'b0;
            sync    <= 1'b0;
        end else begin
            sync <= 1'b0;
            if (!started) begin
                // One idle cycle out of reset, then the first opcode fetch
                started <= 1'b1;
                opfetch <= 1'b1;
                sync    <= 1'b1;
            end else if (!halted) begin
                if (flags[cpu_pkg::HALT]) begin
                    halted <= 1'b1;
                end
                // A pending fetch stalls the sequence
                if (!flags[cpu_pkg::FETCH] || bus_done) begin
                    if (opfetch) begin
                        opfetch <= 1'b0;
                        state   <= 3'd0;
                    end else if (flags[cpu_pkg::END_INSTR]) begin
                        opfetch <= 1'b1;
                        state   <= 3'd0;
                        sync    <= 1'b1;
                    end else begin
                        state <= state + 3'd1;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (flags[cpu_pkg::LOAD_IR] && bus_done) begin
            ir.raw <= fetch_data;
        end
    end

endmodule

/* hw/acc_shift_decode.sv */
module acc_shift_decode (
    input  logic                 carry_flag,
    input  logic [2:0]           state,
    input  logic [2:0]           shift_sel,
    output cpu_pkg::ctrl_flags_t flags
);

    logic use_rot;
    logic use_carry;

    // ASL and ROL double through the adder, LSR and ROR go through the rotator
    always_comb begin
        use_rot   = 1'b0;
        use_carry = 1'b0;
        case (shift_sel)
            cpu_pkg::SHIFT_ROL: use_carry = 1'b1;
            cpu_pkg::SHIFT_LSR: use_rot = 1'b1;
            cpu_pkg::SHIFT_ROR: begin
                use_rot   = 1'b1;
                use_carry = 1'b1;
            end
            default: ;
        endcase
    end

    always_comb begin
        flags = '0;
        case (state)
            3'd0: begin
                // Accumulator onto SB, and through the pass gate onto DB
                flags[cpu_pkg::SET_SB_TO_ACC]     = 1'b1;
                flags[cpu_pkg::SET_SB_TO_DB]      = 1'b1;
                flags[cpu_pkg::SET_INPUT_A_TO_SB] = 1'b1;
                flags[cpu_pkg::SET_INPUT_B_TO_DB] = 1'b1;
                flags[cpu_pkg::SET_ALU_CARRY_HIGH] = use_carry & carry_flag;
                flags[cpu_pkg::ALU_ADD]  = !use_rot;
                flags[cpu_pkg::ALU_ROT]  = use_rot;
                flags[cpu_pkg::LOAD_ALU] = 1'b1;
            end
            3'd1: begin
                // Result back to the accumulator
                flags[cpu_pkg::SET_SB_TO_ALU] = 1'b1;
                flags[cpu_pkg::SET_ACC_TO_SB] = 1'b1;
                // Address latches follow the incremented PC
                flags[cpu_pkg::PC_INC]         = 1'b1;
                flags[cpu_pkg::SET_ADH_TO_PCH] = 1'b1;
                flags[cpu_pkg::LOAD_ABH]       = 1'b1;
                flags[cpu_pkg::SET_ADL_TO_PCL] = 1'b1;
                flags[cpu_pkg::LOAD_ABL]       = 1'b1;
                flags[cpu_pkg::END_INSTR]      = 1'b1;
            end
            default: flags = '0;
        endcase
    end

endmodule

/* hw/cpu_pkg.sv */
package cpu_pkg;

    // Control line positions within the flag vector
    localparam int SET_DB_TO_DATA     = 0;
    localparam int SET_SB_TO_DB       = 1;
    localparam int SET_SB_TO_ACC      = 2;
    localparam int SET_SB_TO_ALU      = 3;
    localparam int SET_INPUT_A_TO_SB  = 4;
    localparam int SET_INPUT_B_TO_DB  = 5;
    localparam int SET_ALU_CARRY_HIGH = 6;
    localparam int ALU_ADD            = 7;
    localparam int ALU_ROT            = 8;
    localparam int LOAD_ALU           = 9;
    localparam int SET_ACC_TO_SB      = 10;
    localparam int CLEAR_CARRY        = 11;
    localparam int SET_CARRY          = 12;
    localparam int PC_INC             = 13;
    localparam int SET_ADH_TO_PCH     = 14;
    localparam int SET_ADL_TO_PCL     = 15;
    localparam int LOAD_ABH           = 16;
    localparam int LOAD_ABL           = 17;
    localparam int LOAD_DATA          = 18;
    localparam int FETCH              = 19;
    localparam int LOAD_IR            = 20;
    localparam int END_INSTR          = 21;
    localparam int HALT               = 22;
    localparam int NUMFLAGS           = 23;

    typedef logic [NUMFLAGS-1:0] ctrl_flags_t;

    // 6502 opcode fields, aaa in the top bits
    typedef struct packed {
        logic [2:0] aaa;
        logic [2:0] bbb;
        logic [1:0] cc;
    } opcode_fields_t;

    typedef union packed {
        logic [7:0]     raw;
        opcode_fields_t f;
    } opcode_u;

    localparam logic [7:0] OP_LDA_IMM = 8'hA9;
    localparam logic [7:0] OP_CLC     = 8'h18;
    localparam logic [7:0] OP_SEC     = 8'h38;
    localparam logic [7:0] OP_NOP     = 8'hEA;
    localparam logic [7:0] OP_HALT    = 8'h00;

    // Accumulator shift group, matched on the fields
    localparam logic [1:0] SHIFT_CC  = 2'b10;
    localparam logic [2:0] SHIFT_BBB = 3'b010;
    localparam logic [2:0] SHIFT_ASL = 3'b000;
    localparam logic [2:0] SHIFT_ROL = 3'b001;
    localparam logic [2:0] SHIFT_LSR = 3'b010;
    localparam logic [2:0] SHIFT_ROR = 3'b011;

    typedef struct packed {
        logic       cyc;
        logic       stb;
        logic       we;
        logic [7:0] adr;
        logic [7:0] dat;
    } wb_req_t;

    typedef struct packed {
        logic       ack;
        logic [7:0] dat;
    } wb_rsp_t;

endpackage
